// ==== bench/emu_ctrl_props.sv ====
`timescale 1ns/1ps

module emu_ctrl_props (
    input  logic                    clk,
    input  logic                    rst,
    input  emu_pkg::host_req_t      host,
    input  logic                    stall_gen,
    input  logic                    dut_clk_en,
    input  logic                    rd_valid
);

    // Every read strobe gets its response in the next cycle
    a_rd_response: assert property (
        @(posedge clk) disable iff (rst)
        host.rd |=> rd_valid
    ) else $error("rd_valid missing one cycle after rd");

    // No response without a strobe
    a_rd_origin: assert property (
        @(posedge clk) disable iff (rst)
        !host.rd |=> !rd_valid
    ) else $error("rd_valid without a preceding rd");

    a_stall_blocks: assert property (
        @(posedge clk) disable iff (rst)
        stall_gen |-> !dut_clk_en
    ) else $error("dut_clk_en high during stall_gen");

    // Block comes out of reset paused
    a_paused_after_reset: assert property (
        @(posedge clk)
        $fell(rst) |-> !dut_clk_en
    ) else $error("dut_clk_en high right after reset");

endmodule

// ==== bench/emu_ctrl_tb.sv ====
`timescale 1ns/1ps

module emu_ctrl_tb;

    typedef enum logic [2:0] {
        OP_WR,
        OP_RD,
        OP_RUN,
        OP_TRIG,
        OP_STALL,
        OP_IDLE
    } op_e;

    typedef struct packed {
        op_e          op;
        logic [2:0]   test;
        logic [11:0]  addr;
        logic [31:0]  data;
        logic [63:0]  exp;
    } row_t;

    localparam int RUN_LIMIT  = 60;
    localparam int RD_LIMIT   = 4;
    localparam int ROW_CYCLES = 64;
    localparam int NUM_TESTS  = 5;

    logic                           clk;
    logic                           rst;
    emu_pkg::host_req_t             host;
    logic [emu_pkg::TRIG_W-1:0]     dut_trig;
    logic                           stall_gen;
    logic                           dut_clk_en;
    logic                           dut_rst;
    logic                           rd_valid;
    logic [emu_pkg::DATA_W-1:0]     rd_data;

    row_t        rows[$];
    logic [2:0]  build_test;
    logic [31:0] lfsr_state;
    bit          table_ready;
    int          err_cnt;
    int          check_cnt;
    int          test_err;
    int          en_cnt;
    int          run_base;
    string       test_names[1:NUM_TESTS];

    emu_ctrl u_emu_ctrl (
        .clk        (clk),
        .rst        (rst),
        .host       (host),
        .dut_trig   (dut_trig),
        .stall_gen  (stall_gen),
        .dut_clk_en (dut_clk_en),
        .dut_rst    (dut_rst),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data)
    );

    bind emu_ctrl emu_ctrl_props u_props (
        .clk        (clk),
        .rst        (rst),
        .host       (host),
        .stall_gen  (stall_gen),
        .dut_clk_en (dut_clk_en),
        .rd_valid   (rd_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Enabled design cycles seen at rising edges
    always @(posedge clk) begin
        if (dut_clk_en) begin
            en_cnt = en_cnt + 1;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int nbits, output logic [31:0] value);
        value = '0;
        for (int b = 0; b < nbits; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        check_cnt++;
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            err_cnt++;
            test_err++;
        end
    endtask

    task automatic add_row(input op_e op, input logic [11:0] addr,
                           input logic [31:0] data, input logic [63:0] exp);
        row_t r;
        r.op   = op;
        r.test = build_test;
        r.addr = addr;
        r.data = data;
        r.exp  = exp;
        rows.push_back(r);
    endtask

    task automatic apply_row(input row_t r);
        int guard;
        guard = 0;
        case (r.op)
            OP_WR: begin
                host.wr    = 1'b1;
                host.addr  = r.addr;
                host.wdata = r.data;
                if (r.addr == emu_pkg::CSR_STAT) begin
                    run_base = en_cnt;
                end
                @(negedge clk);
                host = '0;
            end
            OP_RD: begin
                host.rd   = 1'b1;
                host.addr = r.addr;
                @(negedge clk);
                host = '0;
                while (!rd_valid && guard < RD_LIMIT) begin
                    @(negedge clk);
                    guard++;
                end
                if (!rd_valid) begin
                    $display("ERROR at %0t ns: no read response for address %h",
                             $time, r.addr);
                    err_cnt++;
                    test_err++;
                end else begin
                    check_value(rd_data, r.exp, $sformatf("read of address %h", r.addr));
                end
            end
            OP_RUN: begin
                while (dut_clk_en && guard < RUN_LIMIT) begin
                    @(negedge clk);
                    guard++;
                end
                if (dut_clk_en) begin
                    $display("ERROR at %0t ns: design clock never stopped after %0d cycles",
                             $time, guard);
                    err_cnt++;
                    test_err++;
                end
                check_value(en_cnt - run_base, r.exp, "enabled design cycles");
            end
            OP_TRIG: begin
                dut_trig = r.data;
                @(negedge clk);
            end
            OP_STALL: begin
                stall_gen = r.data[0];
                @(negedge clk);
            end
            default: begin
                // Idle cycles with a check of {dut_rst, dut_clk_en}
                repeat (r.data) begin
                    @(negedge clk);
                    check_value({dut_rst, dut_clk_en}, r.exp, "dut_rst and dut_clk_en");
                end
            end
        endcase
    endtask

    task automatic report_test(input int id);
        if (test_err == 0) begin
            $display("test %0d %s: ok", id, test_names[id]);
        end else begin
            $display("test %0d %s: %0d errors", id, test_names[id], test_err);
        end
        test_err = 0;
    endtask

    task automatic build_table();
        logic [31:0] v_lo;
        logic [31:0] v_hi;
        logic [31:0] v_step;
        logic [31:0] v_en;
        logic [31:0] v_junk;
        logic [31:0] mask;
        logic [63:0] c_start;
        logic [63:0] c_end;
        int          k;

        build_test = 3'd1;
        add_row(OP_RD, emu_pkg::CSR_STAT, '0, 64'h3);
        add_row(OP_RD, emu_pkg::CSR_TRIG_STAT, '0, 64'h0);
        add_row(OP_RD, emu_pkg::CSR_CYCLE_LO, '0, 64'h0);
        add_row(OP_RD, emu_pkg::CSR_CYCLE_HI, '0, 64'h0);
        add_row(OP_RD, emu_pkg::CSR_STEP, '0, 64'h0);
        add_row(OP_RD, emu_pkg::CSR_TRIG_EN, '0, 64'h0);
        add_row(OP_IDLE, '0, 32'd1, 64'b10);

        build_test = 3'd2;
        draw_bits(32, v_lo);
        draw_bits(32, v_hi);
        draw_bits(32, v_step);
        draw_bits(32, v_en);
        draw_bits(32, v_junk);
        add_row(OP_WR, emu_pkg::CSR_CYCLE_LO, v_lo, '0);
        add_row(OP_WR, emu_pkg::CSR_CYCLE_HI, v_hi, '0);
        add_row(OP_WR, emu_pkg::CSR_STEP, v_step, '0);
        add_row(OP_WR, emu_pkg::CSR_TRIG_EN, v_en, '0);
        add_row(OP_WR, emu_pkg::CSR_TRIG_STAT, v_junk, '0);
        // Read straight after the write so a stored value would still show
        add_row(OP_RD, emu_pkg::CSR_TRIG_STAT, '0, 64'h0);
        add_row(OP_WR, 12'h020, v_junk, '0);
        add_row(OP_RD, emu_pkg::CSR_CYCLE_LO, '0, v_lo);
        add_row(OP_RD, emu_pkg::CSR_CYCLE_HI, '0, v_hi);
        add_row(OP_RD, emu_pkg::CSR_STEP, '0, v_step);
        add_row(OP_RD, emu_pkg::CSR_TRIG_EN, '0, v_en);
        add_row(OP_RD, 12'h020, '0, 64'h0);

        // Step k cycles from a random start count
        build_test = 3'd3;
        draw_bits(32, v_lo);
        draw_bits(32, v_hi);
        draw_bits(5, v_step);
        k = (v_step % 20) + 1;
        c_start = {v_hi, v_lo};
        c_end = c_start + 64'(k);
        add_row(OP_WR, emu_pkg::CSR_CYCLE_LO, c_start[31:0], '0);
        add_row(OP_WR, emu_pkg::CSR_CYCLE_HI, c_start[63:32], '0);
        add_row(OP_WR, emu_pkg::CSR_STEP, 32'(k), '0);
        add_row(OP_WR, emu_pkg::CSR_STAT, 32'h0, '0);
        add_row(OP_RUN, '0, '0, 64'(k));
        add_row(OP_RD, emu_pkg::CSR_STAT, '0, 64'h8000_0001);
        add_row(OP_RD, emu_pkg::CSR_CYCLE_LO, '0, c_end[31:0]);
        add_row(OP_RD, emu_pkg::CSR_CYCLE_HI, '0, c_end[63:32]);
        add_row(OP_RD, emu_pkg::CSR_STEP, '0, 64'h0);
        add_row(OP_IDLE, '0, 32'd1, 64'b00);

        // Bit 3 stays outside the mask and bit 20 inside
        build_test = 3'd4;
        draw_bits(32, mask);
        mask = (mask | 32'h0010_0000) & ~32'h0000_0008;
        add_row(OP_WR, emu_pkg::CSR_TRIG_EN, mask, '0);
        add_row(OP_WR, emu_pkg::CSR_STEP, 32'h0, '0);
        add_row(OP_WR, emu_pkg::CSR_STAT, 32'h0, '0);
        add_row(OP_TRIG, '0, 32'h0000_0008, '0);
        add_row(OP_IDLE, '0, 32'd4, 64'b01);
        add_row(OP_TRIG, '0, 32'h0010_0008, '0);
        add_row(OP_IDLE, '0, 32'd2, 64'b00);
        add_row(OP_RD, emu_pkg::CSR_STAT, '0, 64'h1);
        add_row(OP_RD, emu_pkg::CSR_TRIG_STAT, '0, 64'h0010_0008);
        add_row(OP_TRIG, '0, 32'h0, '0);

        build_test = 3'd5;
        draw_bits(32, v_lo);
        draw_bits(5, v_step);
        k = (v_step % 20) + 1;
        c_start = {32'h0, v_lo};
        c_end = c_start + 64'(k);
        add_row(OP_WR, emu_pkg::CSR_CYCLE_LO, c_start[31:0], '0);
        add_row(OP_WR, emu_pkg::CSR_CYCLE_HI, c_start[63:32], '0);
        add_row(OP_WR, emu_pkg::CSR_STEP, 32'(k), '0);
        add_row(OP_STALL, '0, 32'd1, '0);
        add_row(OP_WR, emu_pkg::CSR_STAT, 32'h0, '0);
        add_row(OP_IDLE, '0, 32'd5, 64'b00);
        add_row(OP_RD, emu_pkg::CSR_CYCLE_LO, '0, c_start[31:0]);
        add_row(OP_RD, emu_pkg::CSR_STEP, '0, 64'(k));
        add_row(OP_STALL, '0, 32'd0, '0);
        add_row(OP_RUN, '0, '0, 64'(k));
        add_row(OP_RD, emu_pkg::CSR_CYCLE_LO, '0, c_end[31:0]);
        add_row(OP_RD, emu_pkg::CSR_CYCLE_HI, '0, c_end[63:32]);
        add_row(OP_RD, emu_pkg::CSR_STAT, '0, 64'h8000_0001);
    endtask

    // Watchdog sized from the table length
    initial begin
        wait (table_ready);
        repeat (rows.size() * ROW_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d clock cycles",
                 rows.size() * ROW_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [2:0] cur_test;

        rst = 1'b1;
        host = '0;
        dut_trig = '0;
        stall_gen = 1'b0;
        err_cnt = 0;
        check_cnt = 0;
        test_err = 0;
        en_cnt = 0;
        run_base = 0;
        table_ready = 1'b0;
        lfsr_state = 32'h2e04_6c58;
        test_names[1] = "reset values";
        test_names[2] = "write and read back";
        test_names[3] = "stepping";
        test_names[4] = "triggers";
        test_names[5] = "external stall";

        build_table();
        table_ready = 1'b1;

        repeat (3) @(negedge clk);
        rst = 1'b0;

        cur_test = rows[0].test;
        foreach (rows[i]) begin
            if (rows[i].test != cur_test) begin
                report_test(cur_test);
                cur_test = rows[i].test;
            end
            apply_row(rows[i]);
        end
        report_test(cur_test);

        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== emu_ctrl.f ====
src/emu_pkg.sv
src/emu_run_ctrl.sv
src/emu_cycle_counter.sv
src/emu_step_counter.sv
src/emu_trigger_unit.sv
src/emu_ctrl.sv
bench/emu_ctrl_props.sv
bench/emu_ctrl_tb.sv

// ==== src/emu_ctrl.sv ====
`timescale 1ns/1ps

module emu_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    input  emu_pkg::host_req_t              host,
    input  logic [emu_pkg::TRIG_W-1:0]      dut_trig,
    input  logic                            stall_gen,
    output logic                            dut_clk_en,
    output logic                            dut_rst,
    output logic                            rd_valid,
    output logic [emu_pkg::DATA_W-1:0]      rd_data
);

    emu_pkg::csr_wr_t                   csr_wr;
    logic                               run_en;
    logic                               step_hit;
    logic                               trig_hit;
    logic [emu_pkg::CYCLE_W-1:0]        cycle;
    logic [emu_pkg::DATA_W-1:0]         step_value;
    logic [emu_pkg::TRIG_W-1:0]         trig_stat;
    logic [emu_pkg::TRIG_W-1:0]         trig_en;

    // Plain enable instead of a gated clock
    assign dut_clk_en = run_en;

    emu_run_ctrl u_run_ctrl (
        .clk        (clk),
        .rst        (rst),
        .host       (host),
        .stall_gen  (stall_gen),
        .step_hit   (step_hit),
        .trig_hit   (trig_hit),
        .cycle      (cycle),
        .step_value (step_value),
        .trig_stat  (trig_stat),
        .trig_en    (trig_en),
        .csr_wr     (csr_wr),
        .run_en     (run_en),
        .dut_rst    (dut_rst),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data)
    );

    emu_cycle_counter u_cycle_counter (
        .clk        (clk),
        .rst        (rst),
        .csr_wr     (csr_wr),
        .run_en     (run_en),
        .cycle      (cycle)
    );

    emu_step_counter u_step_counter (
        .clk        (clk),
        .rst        (rst),
        .csr_wr     (csr_wr),
        .run_en     (run_en),
        .step_hit   (step_hit),
        .step_value (step_value)
    );

    emu_trigger_unit u_trigger_unit (
        .clk        (clk),
        .rst        (rst),
        .csr_wr     (csr_wr),
        .run_en     (run_en),
        .dut_trig   (dut_trig),
        .trig_hit   (trig_hit),
        .trig_stat  (trig_stat),
        .trig_en    (trig_en)
    );

endmodule

// ==== src/emu_cycle_counter.sv ====
`timescale 1ns/1ps

module emu_cycle_counter (
    input  logic                            clk,
    input  logic                            rst,
    input  emu_pkg::csr_wr_t                csr_wr,
    input  logic                            run_en,
    output logic [emu_pkg::CYCLE_W-1:0]     cycle
);

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else if (run_en) begin
            cycle <= cycle + 1'b1;
        end else begin
            // Host preload only while the design clock is stopped
            if (csr_wr.cycle_lo) begin
                cycle[emu_pkg::DATA_W-1:0] <= csr_wr.data;
            end
            if (csr_wr.cycle_hi) begin
                cycle[emu_pkg::CYCLE_W-1:emu_pkg::DATA_W] <= csr_wr.data;
            end
        end
    end

endmodule

// ==== src/emu_pkg.sv ====
package emu_pkg;

    // Bus and register widths
    localparam int DATA_W  = 32;
    localparam int ADDR_W  = 12;
    localparam int CYCLE_W = 64;
    localparam int TRIG_W  = 32;

    // Bit positions inside the STAT register
    localparam int STAT_PAUSE_BIT     = 0;
    localparam int STAT_DUT_RST_BIT   = 1;
    localparam int STAT_STEP_TRIG_BIT = 31;

    // Host register map, byte addresses
    typedef enum logic [ADDR_W-1:0] {
        CSR_STAT      = 12'h000,
        CSR_TRIG_STAT = 12'h004,
        CSR_CYCLE_LO  = 12'h008,
        CSR_CYCLE_HI  = 12'h00C,
        CSR_STEP      = 12'h010,
        CSR_TRIG_EN   = 12'h014
    } csr_addr_e;

    typedef enum logic {
        RUN_PAUSED = 1'b0,
        RUN_ACTIVE = 1'b1
    } run_state_e;

    // Single-cycle host access, no back-pressure
    typedef struct packed {
        logic              wr;
        logic              rd;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } host_req_t;

    // Decoded write strobes for the datapath registers
    typedef struct packed {
        logic              cycle_lo;
        logic              cycle_hi;
        logic              step;
        logic              trig_en;
        logic [DATA_W-1:0] data;
    } csr_wr_t;

endpackage

// ==== src/emu_run_ctrl.sv ====
`timescale 1ns/1ps

module emu_run_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    input  emu_pkg::host_req_t              host,
    input  logic                            stall_gen,
    input  logic                            step_hit,
    input  logic                            trig_hit,
    input  logic [emu_pkg::CYCLE_W-1:0]     cycle,
    input  logic [emu_pkg::DATA_W-1:0]      step_value,
    input  logic [emu_pkg::TRIG_W-1:0]      trig_stat,
    input  logic [emu_pkg::TRIG_W-1:0]      trig_en,
    output emu_pkg::csr_wr_t                csr_wr,
    output logic                            run_en,
    output logic                            dut_rst,
    output logic                            rd_valid,
    output logic [emu_pkg::DATA_W-1:0]      rd_data
);

    emu_pkg::run_state_e                state;
    logic                               step_trig;
    logic                               stat_wr;
    logic [emu_pkg::DATA_W-1:0]         stat_word;
    logic [emu_pkg::DATA_W-1:0]         rd_mux;

    // Design clock enable, stall acts without delay
    assign run_en = (state == emu_pkg::RUN_ACTIVE) && !stall_gen;

    // Write decode
    assign stat_wr = host.wr && (host.addr == emu_pkg::CSR_STAT);

    always_comb begin
        csr_wr.cycle_lo = host.wr && (host.addr == emu_pkg::CSR_CYCLE_LO);
        csr_wr.cycle_hi = host.wr && (host.addr == emu_pkg::CSR_CYCLE_HI);
        csr_wr.step     = host.wr && (host.addr == emu_pkg::CSR_STEP);
        csr_wr.trig_en  = host.wr && (host.addr == emu_pkg::CSR_TRIG_EN);
        csr_wr.data     = host.wdata;
    end

    // Run state and design reset
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= emu_pkg::RUN_PAUSED;
            dut_rst   <= 1'b1;
            step_trig <= 1'b0;
        end else if (stat_wr) begin
            // Host write wins over a self-pause at the same edge
            state   <= host.wdata[emu_pkg::STAT_PAUSE_BIT] ?
                       emu_pkg::RUN_PAUSED : emu_pkg::RUN_ACTIVE;
            dut_rst <= host.wdata[emu_pkg::STAT_DUT_RST_BIT];
        end else if (step_hit || trig_hit) begin
            state     <= emu_pkg::RUN_PAUSED;
            step_trig <= step_hit;
        end
    end

    always_comb begin
        stat_word = '0;
        stat_word[emu_pkg::STAT_PAUSE_BIT]     = (state == emu_pkg::RUN_PAUSED);
        stat_word[emu_pkg::STAT_DUT_RST_BIT]   = dut_rst;
        stat_word[emu_pkg::STAT_STEP_TRIG_BIT] = step_trig;
    end

    // Read mux, unmapped addresses give zero
    always_comb begin
        case (host.addr)
            emu_pkg::CSR_STAT:      rd_mux = stat_word;
            emu_pkg::CSR_TRIG_STAT: rd_mux = trig_stat;
            emu_pkg::CSR_CYCLE_LO:  rd_mux = cycle[emu_pkg::DATA_W-1:0];
            emu_pkg::CSR_CYCLE_HI:  rd_mux = cycle[emu_pkg::CYCLE_W-1:emu_pkg::DATA_W];
            emu_pkg::CSR_STEP:      rd_mux = step_value;
            emu_pkg::CSR_TRIG_EN:   rd_mux = trig_en;
            default:                rd_mux = '0;
        endcase
    end

    // Read response one cycle after the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
            rd_data  <= '0;
        end else begin
            rd_valid <= host.rd;
            if (host.rd) begin
                rd_data <= rd_mux;
            end
        end
    end

endmodule

// ==== src/emu_step_counter.sv ====
`timescale 1ns/1ps

module emu_step_counter (
    input  logic                            clk,
    input  logic                            rst,
    input  emu_pkg::csr_wr_t                csr_wr,
    input  logic                            run_en,
    output logic                            step_hit,
    output logic [emu_pkg::DATA_W-1:0]      step_value
);

    logic counting;

    // Zero means free running, no countdown
    assign counting = run_en && (step_value != '0);

    // Last enabled cycle of the step budget
    assign step_hit = run_en && (step_value == emu_pkg::DATA_W'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            step_value <= '0;
        end else if (csr_wr.step) begin
            // Host load overrides the countdown
            step_value <= csr_wr.data;
        end else if (counting) begin
            step_value <= step_value - 1'b1;
        end
    end

endmodule

// ==== src/emu_trigger_unit.sv ====
`timescale 1ns/1ps

module emu_trigger_unit (
    input  logic                            clk,
    input  logic                            rst,
    input  emu_pkg::csr_wr_t                csr_wr,
    input  logic                            run_en,
    input  logic [emu_pkg::TRIG_W-1:0]      dut_trig,
    output logic                            trig_hit,
    output logic [emu_pkg::TRIG_W-1:0]      trig_stat,
    output logic [emu_pkg::TRIG_W-1:0]      trig_en
);

    logic [emu_pkg::TRIG_W-1:0] trig_masked;

    // Only enabled lines can pause the design
    assign trig_masked = dut_trig & trig_en;
    assign trig_hit    = run_en && (|trig_masked);

    // Snapshot of the trigger lines for status reads
    always_ff @(posedge clk) begin
        if (rst) begin
            trig_stat <= '0;
        end else begin
            trig_stat <= dut_trig;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            trig_en <= '0;
        end else if (csr_wr.trig_en) begin
            trig_en <= csr_wr.data[emu_pkg::TRIG_W-1:0];
        end
    end

endmodule
